// File: compile.f
rv_fetch_pkg.sv
fetch_req_if.sv
inst_fetch.sv
inst_mem.sv
fetch_align.sv
fetch_top.sv
tb_fetch_top.sv

// File: fetch_align.sv
`timescale 1ns/1ps

module fetch_align import rv_fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,

  fetch_req_if.pair       req,
  input  logic [ILEN-1:0] rdata_i,
  input  logic            rvalid_i,
  input  logic            flush_i,

  output logic            if_valid_o,
  output logic [XLEN-1:0] if_pc_o,
  output logic [ILEN-1:0] if_inst_o,
  output op_class_e       if_op_o
);

  logic            pend_q;
  logic [XLEN-1:0] pc_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // Address pairing
  // ~~~~~~~~~~~~~~~~~~~~

  // Item in flight, lined up with the memory's registered word
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= req.read & ~req.kill;
    end
  end

  // PC stays frozen while the front end is held
  always_ff @(posedge clk) begin
    if (req.read || !req.hold) begin
      pc_q <= req.addr;
    end
  end

  // A flush in the delivery cycle drops the item
  assign if_valid_o = pend_q & rvalid_i & ~flush_i;
  assign if_pc_o    = pc_q;
  assign if_inst_o  = rdata_i;

  // ~~~~~~~~~~~~~~~~~~~~
  // Predecode
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (rdata_i[6:0])
      OPC_LUI:    if_op_o = OP_LUI;
      OPC_AUIPC:  if_op_o = OP_AUIPC;
      OPC_JAL:    if_op_o = OP_JAL;
      OPC_JALR:   if_op_o = OP_JALR;
      OPC_BRANCH: if_op_o = OP_BRANCH;
      OPC_LOAD:   if_op_o = OP_LOAD;
      OPC_STORE:  if_op_o = OP_STORE;
      OPC_ALUI:   if_op_o = OP_ALUI;
      OPC_ALU:    if_op_o = OP_ALU;
      OPC_FENCE:  if_op_o = OP_FENCE;
      OPC_SYSTEM: if_op_o = OP_SYSTEM;
      default:    if_op_o = OP_ILLEGAL;
    endcase
  end

endmodule

// File: fetch_req_if.sv
`timescale 1ns/1ps

interface fetch_req_if import rv_fetch_pkg::*; ();

  logic            read;
  logic [XLEN-1:0] addr;
  logic            kill;
  logic            hold;

  modport source (
    output read,
    output addr,
    output kill,
    output hold
  );

  modport mem (
    input read,
    input addr
  );

  modport pair (
    input read,
    input addr,
    input kill,
    input hold
  );

endinterface

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top import rv_fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,

  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            branch_taken_i,
  input  logic [XLEN-1:0] branch_target_addr_i,
  input  logic [XLEN-1:0] new_pc_i,

  input  logic [XLEN-1:0] paddr_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [ILEN-1:0] pwdata_i,
  output logic [ILEN-1:0] prdata_o,
  output logic            pready_o,
  output logic            pslverr_o,

  output logic            if_valid_o,
  output logic [XLEN-1:0] if_pc_o,
  output logic [ILEN-1:0] if_inst_o,
  output op_class_e       if_op_o
);

  fetch_req_if req_if ();

  logic [ILEN-1:0] imem_rdata;
  logic            imem_rvalid;

  inst_fetch u_inst_fetch (
    .clk                  (clk),
    .rstn                 (rstn),
    .stall_i              (stall_i),
    .flush_i              (flush_i),
    .branch_taken_i       (branch_taken_i),
    .branch_target_addr_i (branch_target_addr_i),
    .new_pc_i             (new_pc_i),
    .req                  (req_if.source)
  );

  inst_mem u_inst_mem (
    .clk       (clk),
    .rstn      (rstn),
    .req       (req_if.mem),
    .rdata_o   (imem_rdata),
    .rvalid_o  (imem_rvalid),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  fetch_align u_fetch_align (
    .clk        (clk),
    .rstn       (rstn),
    .req        (req_if.pair),
    .rdata_i    (imem_rdata),
    .rvalid_i   (imem_rvalid),
    .flush_i    (flush_i),
    .if_valid_o (if_valid_o),
    .if_pc_o    (if_pc_o),
    .if_inst_o  (if_inst_o),
    .if_op_o    (if_op_o)
  );

endmodule

// File: inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch import rv_fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,

  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            branch_taken_i,
  input  logic [XLEN-1:0] branch_target_addr_i,
  input  logic [XLEN-1:0] new_pc_i,

  fetch_req_if.source     req
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_n;

  // ~~~~~~~~~~~~~~~~~~~~
  // Fetch request
  // ~~~~~~~~~~~~~~~~~~~~

  // Branch target goes to the memory in the same cycle
  always_comb begin
    if (branch_taken_i) begin
      req.addr = branch_target_addr_i;
    end else begin
      req.addr = pc_q;
    end
  end

  // A taken branch still issues under stall, so the target is not lost
  assign req.read = ~flush_i & (~stall_i | branch_taken_i);
  assign req.kill = flush_i;
  assign req.hold = stall_i;

  // ~~~~~~~~~~~~~~~~~~~~
  // Next PC
  // ~~~~~~~~~~~~~~~~~~~~

  // Priority is flush, then branch, then stall
  always_comb begin
    if (flush_i) begin
      pc_n = new_pc_i;
    end else if (branch_taken_i) begin
      pc_n = branch_target_addr_i + XLEN'(4);
    end else if (stall_i) begin
      pc_n = pc_q;
    end else begin
      pc_n = pc_q + XLEN'(4);
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      pc_q <= START_ADDR;
    end else begin
      pc_q <= pc_n;
    end
  end

endmodule

// File: inst_mem.sv
`timescale 1ns/1ps

module inst_mem import rv_fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,

  fetch_req_if.mem        req,
  output logic [ILEN-1:0] rdata_o,
  output logic            rvalid_o,

  input  logic [XLEN-1:0] paddr_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [ILEN-1:0] pwdata_i,
  output logic [ILEN-1:0] prdata_o,
  output logic            pready_o,
  output logic            pslverr_o
);

  logic [ILEN-1:0]    mem [IMEM_WORDS];

  logic [IMEM_AW-1:0] fetch_idx;
  logic               fetch_in_range;
  logic [IMEM_AW-1:0] apb_idx;
  logic               apb_in_range;
  logic               apb_setup;
  logic               apb_access;

  assign fetch_idx      = req.addr[IMEM_AW+1:2];
  assign fetch_in_range = req.addr < XLEN'(IMEM_WORDS * 4);
  assign apb_idx        = paddr_i[IMEM_AW+1:2];
  assign apb_in_range   = paddr_i < XLEN'(IMEM_WORDS * 4);
  assign apb_setup      = psel_i & ~penable_i;
  assign apb_access     = psel_i & penable_i;

  // ~~~~~~~~~~~~~~~~~~~~
  // Fetch port
  // ~~~~~~~~~~~~~~~~~~~~

  // Word holds its value while no fetch is issued
  always_ff @(posedge clk) begin
    if (req.read) begin
      rdata_o <= fetch_in_range ? mem[fetch_idx] : NOP_INST;
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req.read;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // APB host port
  // ~~~~~~~~~~~~~~~~~~~~

  // A fetch of the word written in the same cycle sees the old word
  always_ff @(posedge clk) begin
    if (apb_access && pwrite_i && apb_in_range) begin
      mem[apb_idx] <= pwdata_i;
    end
  end

  // Read data and error are sampled in setup and shown in the access phase
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      prdata_o  <= '0;
      pslverr_o <= 1'b0;
    end else if (apb_setup) begin
      prdata_o  <= (apb_in_range && !pwrite_i) ? mem[apb_idx] : '0;
      pslverr_o <= ~apb_in_range;
    end else if (apb_access) begin
      pslverr_o <= 1'b0;
    end
  end

  // No wait states
  assign pready_o = 1'b1;

endmodule

// File: rv_fetch_pkg.sv
package rv_fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Widths and memory map
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned XLEN       = 32;
  localparam int unsigned ILEN       = 32;
  localparam int unsigned IMEM_WORDS = 256;
  localparam int unsigned IMEM_AW    = 8;

  localparam logic [XLEN-1:0] START_ADDR = 32'h0000_0000;
  // addi x0,x0,0
  localparam logic [ILEN-1:0] NOP_INST   = 32'h0000_0013;

  // ~~~~~~~~~~~~~~~~~~~~
  // Major opcodes, bits 6..0
  // ~~~~~~~~~~~~~~~~~~~~
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_ALUI   = 7'b0010011;
  localparam logic [6:0] OPC_ALU    = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BRANCH,
    OP_LOAD,
    OP_STORE,
    OP_ALUI,
    OP_ALU,
    OP_FENCE,
    OP_SYSTEM,
    OP_ILLEGAL
  } op_class_e;

endpackage

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top import rv_fetch_pkg::*; ();

  // Budgets for APB load, sequential, stall, branch, flush and predecode
  localparam int TEST_CYCLES = 1100 + 30 + 30 + 30 + 20 + 80;

  logic            clk = 1'b0;
  logic            rstn;
  logic            stall_i;
  logic            flush_i;
  logic            branch_taken_i;
  logic [XLEN-1:0] branch_target_addr_i;
  logic [XLEN-1:0] new_pc_i;
  logic [XLEN-1:0] paddr_i;
  logic            psel_i;
  logic            penable_i;
  logic            pwrite_i;
  logic [ILEN-1:0] pwdata_i;
  logic [ILEN-1:0] prdata_o;
  logic            pready_o;
  logic            pslverr_o;
  logic            if_valid_o;
  logic [XLEN-1:0] if_pc_o;
  logic [ILEN-1:0] if_inst_o;
  op_class_e       if_op_o;

  logic [ILEN-1:0] shadow [IMEM_WORDS];
  logic [XLEN-1:0] issue_q [$];
  logic [XLEN-1:0] pc_model;
  integer          seed = 32'hb99ed756;
  int              checks = 0;
  int              errors = 0;
  int              delivered = 0;
  int              err_mark;
  int              item_mark;

  fetch_top dut_i (.*);

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic void ref_fetch(input logic [XLEN-1:0] addr,
                                    output logic [ILEN-1:0] inst, output op_class_e op);
    if (addr < IMEM_WORDS * 4) begin
      inst = shadow[addr[IMEM_AW+1:2]];
    end else begin
      inst = NOP_INST;
    end
    case (inst[6:0])
      7'h37:   op = OP_LUI;
      7'h17:   op = OP_AUIPC;
      7'h6f:   op = OP_JAL;
      7'h67:   op = OP_JALR;
      7'h63:   op = OP_BRANCH;
      7'h03:   op = OP_LOAD;
      7'h23:   op = OP_STORE;
      7'h13:   op = OP_ALUI;
      7'h33:   op = OP_ALU;
      7'h0f:   op = OP_FENCE;
      7'h73:   op = OP_SYSTEM;
      default: op = OP_ILLEGAL;
    endcase
  endfunction

  // Expected issue per cycle with flush over branch over stall
  always @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      pc_model = START_ADDR;
      issue_q.delete();
    end else begin
      if (!flush_i && (!stall_i || branch_taken_i)) begin
        issue_q.push_back(branch_taken_i ? branch_target_addr_i : pc_model);
      end
      if (flush_i) begin
        pc_model = new_pc_i;
      end else if (branch_taken_i) begin
        pc_model = branch_target_addr_i + 4;
      end else if (!stall_i) begin
        pc_model = pc_model + 4;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [ILEN-1:0] exp,
                            input logic [ILEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input op_class_e exp, input op_class_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %s, got %s (%h)", $time, name,
               exp.name(), act.name(), act);
    end
  endtask

  // Outputs are settled mid-cycle
  always @(negedge clk) begin : monitor
    logic            exp_valid;
    logic [XLEN-1:0] exp_pc;
    logic [ILEN-1:0] exp_inst;
    op_class_e       exp_op;
    if (rstn) begin
      exp_valid = 1'b0;
      if (issue_q.size() > 0) begin
        exp_pc    = issue_q.pop_front();
        exp_valid = !flush_i;
      end
      check_flag("if_valid_o", exp_valid, if_valid_o);
      if (exp_valid && if_valid_o) begin
        ref_fetch(exp_pc, exp_inst, exp_op);
        check_addr("if_pc_o", exp_pc, if_pc_o);
        check_word("if_inst_o", exp_inst, if_inst_o);
        check_op("if_op_o", exp_op, if_op_o);
        delivered++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic apply_reset();
    rstn = 1'b0;
    run_cycles(2);
    rstn = 1'b1;
  endtask

  // Setup then access phase with no wait states
  task automatic apb_xfer(input logic [XLEN-1:0] addr, input logic wr,
                          input logic [ILEN-1:0] wdata,
                          output logic [ILEN-1:0] rdata, output logic err);
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    next_cycle();
    penable_i = 1'b1;
    @(negedge clk);
    rdata = prdata_o;
    err   = pslverr_o;
    check_flag("pready_o", 1'b1, pready_o);
    next_cycle();
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic begin_test();
    err_mark  = errors;
    item_mark = delivered;
  endtask

  task automatic end_test(input string name, input int min_items);
    if (delivered - item_mark < min_items) begin
      errors++;
      $display("Error: %s delivered %0d instructions, at least %0d were expected",
               name, delivered - item_mark, min_items);
    end
    $display("Test %s finished with %0d errors", name, errors - err_mark);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [ILEN-1:0] rd;
    logic            err;
    logic [XLEN-1:0] target;
    logic [6:0]      opcodes [12];
    opcodes = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                7'h23, 7'h13, 7'h33, 7'h0f, 7'h73, 7'h7f};
    rstn                 = 1'b0;
    stall_i              = 1'b0;
    flush_i              = 1'b1;
    branch_taken_i       = 1'b0;
    branch_target_addr_i = '0;
    new_pc_i             = START_ADDR;
    paddr_i              = '0;
    psel_i               = 1'b0;
    penable_i            = 1'b0;
    pwrite_i             = 1'b0;
    pwdata_i             = '0;
    apply_reset();

    // Flush held so the fetch path stays quiet while loading
    begin_test();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      shadow[i] = $random(seed);
      apb_xfer(XLEN'(i * 4), 1'b1, shadow[i], rd, err);
      check_flag("pslverr_o", 1'b0, err);
    end
    for (int i = 0; i < IMEM_WORDS; i++) begin
      apb_xfer(XLEN'(i * 4), 1'b0, '0, rd, err);
      check_word("prdata_o", shadow[i], rd);
      check_flag("pslverr_o", 1'b0, err);
    end
    apb_xfer(32'h0000_0400, 1'b0, '0, rd, err);
    check_flag("pslverr_o", 1'b1, err);
    apb_xfer(32'h0000_0800, 1'b1, 32'hdead_beef, rd, err);
    check_flag("pslverr_o", 1'b1, err);
    end_test("APB load and readback", 0);

    begin_test();
    flush_i = 1'b0;
    apply_reset();
    run_cycles(20);
    end_test("sequential fetch", 15);

    begin_test();
    run_cycles(3);
    stall_i = 1'b1;
    run_cycles(5);
    stall_i = 1'b0;
    run_cycles(6);
    end_test("stall", 8);

    begin_test();
    target               = $random(seed) & 32'h0000_03fc;
    branch_taken_i       = 1'b1;
    branch_target_addr_i = target;
    run_cycles(1);
    branch_taken_i       = 1'b0;
    run_cycles(4);
    target               = $random(seed) & 32'h0000_03fc;
    stall_i              = 1'b1;
    branch_taken_i       = 1'b1;
    branch_target_addr_i = target;
    run_cycles(1);
    branch_taken_i       = 1'b0;
    run_cycles(2);
    stall_i              = 1'b0;
    run_cycles(4);
    end_test("taken branch", 10);

    begin_test();
    new_pc_i = 32'h0000_0200;
    flush_i  = 1'b1;
    run_cycles(1);
    flush_i  = 1'b0;
    run_cycles(5);
    end_test("flush", 4);

    // Past the end of memory and then one word per opcode class
    begin_test();
    branch_taken_i       = 1'b1;
    branch_target_addr_i = 32'h0000_1000;
    run_cycles(1);
    branch_taken_i       = 1'b0;
    run_cycles(4);
    flush_i  = 1'b1;
    new_pc_i = 32'h0000_0100;
    for (int k = 0; k < 12; k++) begin
      shadow[64 + k] = ($random(seed) & 32'hffff_ff80) | ILEN'(opcodes[k]);
      apb_xfer(32'h0000_0100 + XLEN'(k * 4), 1'b1, shadow[64 + k], rd, err);
    end
    flush_i = 1'b0;
    run_cycles(14);
    end_test("out of range and predecode", 16);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + 100) * 10);
    $display("Timeout: the tests did not finish within their cycle budget");
    $display(">>> FAIL");
    $finish;
  end

endmodule
